//--- Bender.yml
package:
  name: branch_predictor

sources:
  # Packages first, the bus package imports the types package
  - files:
      - common/branch_types_pkg.sv
      - common/pred_bus_pkg.sv

  # Predictor RTL, top level last
  - files:
      - hw/predictor_ctrl.sv
      - hw/history_table.sv
      - hw/target_buffer.sv
      - hw/branch_predictor.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tb/branch_predictor_sva.sv
      - tb/tb_branch_predictor.sv

//--- common/branch_types_pkg.sv
////////////////////
// Table contents and counter states for the fetch-stage predictor
// Entries keep the full PC and the tag is taken from it above the index
// PC bit 0 is never used because instructions are halfword aligned
////////////////////
`default_nettype none

package branch_types_pkg;

  parameter int PC_W = 16;                  // Processor address width

  // Two-bit saturating counter, top bit set means taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } ctr_state_e;

  // Branch history entry
  typedef struct packed {
    logic              valid;               // Entry holds a branch
    logic [PC_W-1:0]   pc;                  // Full branch PC, tag source
    ctr_state_e        ctr;                 // Prediction state
  } hist_entry_t;

  // Branch target entry
  typedef struct packed {
    logic              valid;               // Entry holds a target
    logic [PC_W-1:0]   pc;                  // Full branch PC, tag source
    logic [PC_W-1:0]   target;              // Last resolved target
  } tgt_entry_t;

endpackage

`default_nettype wire

//--- common/pred_bus_pkg.sv
////////////////////
// Buses between fetch, decode and the predictor
// A resolve is taken in every cycle it is presented, with no handshake
////////////////////
`default_nettype none

package pred_bus_pkg;

  import branch_types_pkg::*;

  // Combinational lookup result returned to fetch
  typedef struct packed {
    logic              taken;               // Predict taken
    logic              hit;                 // History tag match
    ctr_state_e        counter;             // Stored state or strong_nt
    logic              target_hit;          // Target buffer tag match
    logic [PC_W-1:0]   target;              // Predicted target, zero on miss
  } lookup_rsp_t;

  // Update from decode, one per cycle
  typedef struct packed {
    logic              hist_we;             // Write history table
    logic              tgt_we;              // Write target buffer
    logic [PC_W-1:0]   pc;                  // Branch PC
    ctr_state_e        counter;             // State predicted for this branch
    logic              taken;               // Actual outcome
    logic [PC_W-1:0]   target;              // Actual target
  } resolve_t;

endpackage

`default_nettype wire

//--- flist.f
common/branch_types_pkg.sv
common/pred_bus_pkg.sv
hw/predictor_ctrl.sv
hw/history_table.sv
hw/target_buffer.sv
hw/branch_predictor.sv
tb/branch_predictor_sva.sv
tb/tb_branch_predictor.sv

//--- hw/branch_predictor.sv
////////////////////
// Fetch-stage dynamic branch predictor
// Lookup is combinational on pc, updates show on the next cycle
////////////////////
`timescale 1ns/100ps
`default_nettype none

module branch_predictor
  import branch_types_pkg::*, pred_bus_pkg::*;
#(
  parameter int INDEX_BITS = 3
) (
  input  logic              clk,            // System clock
  input  logic              rst,            // Sync reset, active high
  input  logic              enable,         // Predictor enable
  input  logic [PC_W-1:0]   pc,             // Fetch PC
  input  resolve_t          resolve,        // Decode stage update
  output lookup_rsp_t       rsp             // Lookup response
);

  logic [PC_W-1:0] hist_addr;               // History port
  logic            hist_we;
  hist_entry_t     hist_wdata;
  hist_entry_t     hist_rdata;
  logic            hist_hit;
  logic [PC_W-1:0] tgt_rd_pc;               // Target buffer ports
  logic            tgt_we;
  logic [PC_W-1:0] tgt_wr_pc;
  logic [PC_W-1:0] tgt_wdata;
  logic            tgt_hit;
  logic [PC_W-1:0] tgt_target;

  predictor_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
    .enable, .pc, .resolve,
    .hist_addr, .hist_we, .hist_wdata, .hist_rdata, .hist_hit,
    .tgt_rd_pc, .tgt_we, .tgt_wr_pc, .tgt_wdata, .tgt_hit, .tgt_target,
    .rsp
  );

  history_table #(.INDEX_BITS(INDEX_BITS)) u_hist (
    .clk, .rst,
    .addr  (hist_addr),
    .we    (hist_we),
    .wdata (hist_wdata),
    .rdata (hist_rdata),
    .hit   (hist_hit)
  );

  target_buffer #(.INDEX_BITS(INDEX_BITS)) u_tgt (
    .clk, .rst,
    .rd_pc  (tgt_rd_pc),
    .wr_pc  (tgt_wr_pc),
    .we     (tgt_we),
    .wdata  (tgt_wdata),
    .hit    (tgt_hit),
    .target (tgt_target)
  );

endmodule

`default_nettype wire

//--- hw/history_table.sv
////////////////////
// Tagged counter table, 2**INDEX_BITS entries
// One address for read and write, read is asynchronous
// Write lands on the next rising edge
////////////////////
`timescale 1ns/100ps
`default_nettype none

module history_table
  import branch_types_pkg::*;
#(
  parameter int INDEX_BITS = 3
) (
  input  logic              clk,            // System clock
  input  logic              rst,            // Sync reset, active high
  input  logic [PC_W-1:0]   addr,           // Shared read/write PC
  input  logic              we,             // Write strobe
  input  hist_entry_t       wdata,          // Entry to store
  output hist_entry_t       rdata,          // Entry at addr
  output logic              hit             // Valid and tag match
);

  localparam int DEPTH   = 1 << INDEX_BITS;
  localparam int TAG_LSB = INDEX_BITS + 1;  // Bit 0 unused

  hist_entry_t             mem [DEPTH];     // Table storage
  logic [INDEX_BITS-1:0]   idx;             // Entry select

  assign idx = addr[INDEX_BITS:1];

  // Only valid bits are cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i].valid <= 1'b0;
      end
    end else if (we) begin
      mem[idx] <= wdata;
    end
  end

  assign rdata = mem[idx];

  // Tag is everything above the index
  assign hit = rdata.valid && (rdata.pc[PC_W-1:TAG_LSB] == addr[PC_W-1:TAG_LSB]);

endmodule

`default_nettype wire

//--- hw/predictor_ctrl.sv
////////////////////
// Predictor control, purely combinational
// History port is shared so a history write blanks that cycle's lookup
// All writes are dropped while enable is low
////////////////////
`timescale 1ns/100ps
`default_nettype none

module predictor_ctrl
  import branch_types_pkg::*, pred_bus_pkg::*;
#(
  parameter int INDEX_BITS = 3
) (
  input  logic              enable,         // Predictor enable
  input  logic [PC_W-1:0]   pc,             // Fetch PC
  input  resolve_t          resolve,        // Decode stage update
  output logic [PC_W-1:0]   hist_addr,      // Shared history address
  output logic              hist_we,        // History write strobe
  output hist_entry_t       hist_wdata,     // History write entry
  input  hist_entry_t       hist_rdata,     // History read entry
  input  logic              hist_hit,       // History tag match
  output logic [PC_W-1:0]   tgt_rd_pc,      // Target lookup PC
  output logic              tgt_we,         // Target write strobe
  output logic [PC_W-1:0]   tgt_wr_pc,      // Target write PC
  output logic [PC_W-1:0]   tgt_wdata,      // Target write data
  input  logic              tgt_hit,        // Target tag match
  input  logic [PC_W-1:0]   tgt_target,     // Target read data
  output lookup_rsp_t       rsp             // Lookup response
);

  // Index must leave at least one tag bit above it
  if (INDEX_BITS < 1 || INDEX_BITS > PC_W - 2) begin : g_bad_index
    $error("INDEX_BITS out of range for PC width");
  end

  ctr_state_e base_ctr;                     // State to be stepped
  ctr_state_e next_ctr;                     // State to be written

  // Saturating step up on taken, down on not taken
  function automatic ctr_state_e step_ctr(input ctr_state_e cur, input logic taken);
    ctr_state_e nxt;
    nxt = cur;
    case (cur)
      strong_nt: nxt = taken ? weak_nt  : strong_nt;
      weak_nt:   nxt = taken ? weak_t   : strong_nt;
      weak_t:    nxt = taken ? strong_t : weak_nt;
      strong_t:  nxt = taken ? strong_t : weak_t;
      default:   nxt = strong_nt;
    endcase
    return nxt;
  endfunction

  ////////////////////
  // Write side
  ////////////////////
  assign hist_we   = enable & resolve.hist_we;
  assign hist_addr = hist_we ? resolve.pc : pc;          // Update owns the port

  // Hit at resolve PC steps the carried state, a miss installs fresh
  assign base_ctr = hist_hit ? resolve.counter : strong_nt;
  assign next_ctr = step_ctr(base_ctr, resolve.taken);

  always_comb begin
    hist_wdata       = '0;
    hist_wdata.valid = 1'b1;
    hist_wdata.pc    = resolve.pc;
    hist_wdata.ctr   = next_ctr;
  end

  assign tgt_we    = enable & resolve.tgt_we;
  assign tgt_wr_pc = resolve.pc;
  assign tgt_wdata = resolve.target;
  assign tgt_rd_pc = pc;                                 // Separate read port

  ////////////////////
  // Lookup response
  ////////////////////
  always_comb begin
    rsp = '0;                                            // Disabled or port busy
    if (enable && !resolve.hist_we) begin
      rsp.hit        = hist_hit;
      rsp.counter    = hist_hit ? hist_rdata.ctr : strong_nt;
      rsp.taken      = hist_hit & rsp.counter[1];        // Top bit means taken
      rsp.target_hit = tgt_hit;
      rsp.target     = tgt_target;                       // Already zero on miss
    end
  end

endmodule

`default_nettype wire

//--- hw/target_buffer.sv
////////////////////
// Tagged target table, 2**INDEX_BITS entries
// Independent write port so updates never block lookups
// Target reads as zero on a miss
////////////////////
`timescale 1ns/100ps
`default_nettype none

module target_buffer
  import branch_types_pkg::*;
#(
  parameter int INDEX_BITS = 3
) (
  input  logic              clk,            // System clock
  input  logic              rst,            // Sync reset, active high
  input  logic [PC_W-1:0]   rd_pc,          // Lookup PC
  input  logic [PC_W-1:0]   wr_pc,          // Update PC
  input  logic              we,             // Write strobe
  input  logic [PC_W-1:0]   wdata,          // Resolved target
  output logic              hit,            // Valid and tag match
  output logic [PC_W-1:0]   target          // Stored target or zero
);

  localparam int DEPTH   = 1 << INDEX_BITS;
  localparam int TAG_LSB = INDEX_BITS + 1;

  tgt_entry_t              mem [DEPTH];     // Buffer storage
  tgt_entry_t              rd_entry;        // Entry at rd_pc
  logic [INDEX_BITS-1:0]   rd_idx;
  logic [INDEX_BITS-1:0]   wr_idx;

  assign rd_idx = rd_pc[INDEX_BITS:1];
  assign wr_idx = wr_pc[INDEX_BITS:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i].valid <= 1'b0;                            // Payload kept
      end
    end else if (we) begin
      mem[wr_idx] <= '{valid: 1'b1, pc: wr_pc, target: wdata};
    end
  end

  assign rd_entry = mem[rd_idx];
  assign hit      = rd_entry.valid && (rd_entry.pc[PC_W-1:TAG_LSB] == rd_pc[PC_W-1:TAG_LSB]);
  assign target   = hit ? rd_entry.target : '0;

endmodule

`default_nettype wire

//--- tb/branch_predictor_sva.sv
////////////////////
// Concurrent checks bound onto the predictor top level
// Sampled on the rising edge, response rules only
////////////////////
`timescale 1ns/100ps
`default_nettype none

module branch_predictor_sva
  import branch_types_pkg::*, pred_bus_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        enable,
  input resolve_t    resolve,
  input lookup_rsp_t rsp
);

  // Taken needs a history hit
  a_taken_needs_hit: assert property (@(posedge clk) disable iff (rst) rsp.taken |-> rsp.hit)
    else $error("taken without a history hit");

  // Nothing predicted while the tables clear
  a_quiet_after_rst: assert property (@(posedge clk) (rst || $past(rst)) |-> !rsp.taken)
    else $error("taken during or right after reset");

  // History write owns the port
  a_busy_zero: assert property (@(posedge clk) disable iff (rst)
    (enable && resolve.hist_we) |-> (rsp == '0))
    else $error("nonzero response during a history write");

endmodule

bind branch_predictor branch_predictor_sva u_sva (
  .clk, .rst, .enable, .resolve, .rsp
);

`default_nettype wire

//--- tb/tb_branch_predictor.sv
////////////////////
// Testbench for the branch predictor playing both fetch and decode
// A model of both tables checks rsp at every falling edge after reset
// Random PCs come from a small set so entries hit and alias
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_branch_predictor
  import branch_types_pkg::*, pred_bus_pkg::*;
();

  localparam int INDEX_BITS = 3;
  localparam int DEPTH      = 1 << INDEX_BITS;
  localparam int RUN_CYCLES = 300;                       // Bound on all tests together
  localparam int MAX_CYCLES = 2 * RUN_CYCLES;

  logic            clk;
  logic            rst;
  logic            enable;
  logic [PC_W-1:0] pc;
  resolve_t        resolve;
  lookup_rsp_t     rsp;

  hist_entry_t     ref_hist [DEPTH];                     // Model of history table
  tgt_entry_t      ref_tgt  [DEPTH];                     // Model of target buffer
  lookup_rsp_t     exp_rsp;
  logic [31:0]     lfsr       = 32'h4cd99fcd;
  int              cycles     = 0;
  int              num_checks = 0;
  int              errors     = 0;
  logic [PC_W-1:0] pc_set [8] = '{16'h1004, 16'h2004, 16'h0108, 16'h0208,
                                  16'h0010, 16'h3006, 16'h400a, 16'h100c};
  ctr_state_e      train  [6] = '{weak_nt, weak_t, strong_t, strong_t, weak_t, weak_nt};

  branch_predictor #(.INDEX_BITS(INDEX_BITS)) dut (
    .clk, .rst, .enable, .pc, .resolve, .rsp
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                               // 8 ns period
  end

  ////////////////////
  // Reference model
  ////////////////////
  function automatic int index_of(input logic [PC_W-1:0] p);
    return int'(p[INDEX_BITS:1]);                        // Bit 0 unused
  endfunction

  function automatic logic same_tag(input logic [PC_W-1:0] a, input logic [PC_W-1:0] b);
    return (a >> (INDEX_BITS + 1)) == (b >> (INDEX_BITS + 1));
  endfunction

  function automatic ctr_state_e saturate(input ctr_state_e c, input logic t);
    if (t) return (c == strong_t) ? strong_t : ctr_state_e'(c + 2'd1);
    return (c == strong_nt) ? strong_nt : ctr_state_e'(c - 2'd1);
  endfunction

  function automatic lookup_rsp_t ref_lookup(input logic en, input logic [PC_W-1:0] p,
                                             input resolve_t res);
    lookup_rsp_t r;
    int          i;
    r = '0;
    i = index_of(p);
    if (en && !res.hist_we) begin                        // Port busy reads zero
      if (ref_hist[i].valid && same_tag(ref_hist[i].pc, p)) begin
        r.hit     = 1'b1;
        r.counter = ref_hist[i].ctr;
        r.taken   = (ref_hist[i].ctr == weak_t) || (ref_hist[i].ctr == strong_t);
      end
      if (ref_tgt[i].valid && same_tag(ref_tgt[i].pc, p)) begin
        r.target_hit = 1'b1;
        r.target     = ref_tgt[i].target;
      end
    end
    return r;
  endfunction

  function automatic void ref_update(input logic en, input resolve_t res);
    int         i;
    ctr_state_e base;
    i = index_of(res.pc);
    if (!en) return;
    if (res.hist_we) begin
      base = (ref_hist[i].valid && same_tag(ref_hist[i].pc, res.pc)) ? res.counter : strong_nt;
      ref_hist[i] = '{valid: 1'b1, pc: res.pc, ctr: saturate(base, res.taken)};
    end
    if (res.tgt_we) ref_tgt[i] = '{valid: 1'b1, pc: res.pc, target: res.target};
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);                            // One step per bit
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  function automatic resolve_t mk_res(input logic hw, input logic tw, input logic [PC_W-1:0] p,
                                      input ctr_state_e c, input logic t,
                                      input logic [PC_W-1:0] tg);
    return '{hist_we: hw, tgt_we: tw, pc: p, counter: c, taken: t, target: tg};
  endfunction

  ////////////////////
  // Drive and compare
  ////////////////////
  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    num_checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic drive(input logic en, input logic [PC_W-1:0] p, input resolve_t res);
    @(posedge clk);
    enable  <= en;
    pc      <= p;
    resolve <= res;
  endtask

  task automatic end_test(input string name, input int err_start);
    drive(1'b1, '0, '0);                                 // Idle cycle
    @(posedge clk);                                      // Last compare has run
    if (errors == err_start) $display("test %s: ok", name);
    else $display("test %s: %0d mismatches", name, errors - err_start);
  endtask

  // Compare first and then let this cycle's resolve land in the model
  always @(negedge clk) begin
    if (!rst) begin
      exp_rsp = ref_lookup(enable, pc, resolve);
      check("rsp", rsp, exp_rsp);
      ref_update(enable, resolve);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, run exceeded %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // Tests
  ////////////////////
  initial begin
    int              err_start;
    logic [15:0]     r;
    logic            en;
    logic [PC_W-1:0] p;
    resolve_t        res;
    ctr_state_e      carried;
    rst     = 1'b1;
    enable  = 1'b0;
    pc      = '0;
    resolve = '0;
    for (int i = 0; i < DEPTH; i++) begin
      ref_hist[i] = '0;
      ref_tgt[i]  = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    err_start = errors;
    for (int i = 0; i < 4; i++) begin
      drive(1'b1, pc_set[i*2], '0);
      @(negedge clk);
      check("rsp", rsp, '0);                             // All entries invalid
    end
    end_test("reset", err_start);

    err_start = errors;
    carried   = strong_nt;                               // Ignored on the first miss
    for (int i = 0; i < 6; i++) begin
      drive(1'b1, 16'h1004, mk_res(1'b1, 1'b0, 16'h1004, carried, i < 4, '0));
      drive(1'b1, 16'h1004, '0);
      @(negedge clk);
      check("rsp.counter", rsp.counter, train[i]);
      check("rsp.taken", rsp.taken, train[i][1]);
      carried = train[i];
    end
    end_test("counter training", err_start);

    err_start = errors;
    drive(1'b1, 16'h2004, mk_res(1'b1, 1'b0, 16'h2004, strong_t, 1'b1, '0));
    drive(1'b1, 16'h2004, '0);
    @(negedge clk);
    check("rsp.hit", rsp.hit, 1'b1);
    check("rsp.counter", rsp.counter, weak_nt);          // Fresh install
    drive(1'b1, 16'h1004, '0);
    @(negedge clk);
    check("rsp.hit", rsp.hit, 1'b0);                     // Evicted
    end_test("aliasing", err_start);

    err_start = errors;
    drive(1'b1, 16'h0108, mk_res(1'b0, 1'b1, 16'h0108, strong_nt, 1'b1, 16'hbeef));
    drive(1'b1, 16'h0108, '0);
    @(negedge clk);
    check("rsp.target_hit", rsp.target_hit, 1'b1);
    check("rsp.target", rsp.target, 16'hbeef);
    check("rsp.hit", rsp.hit, 1'b0);
    drive(1'b1, 16'h0208, '0);                           // Same index with another tag
    @(negedge clk);
    check("rsp", rsp, '0);
    end_test("target buffer", err_start);

    err_start = errors;
    drive(1'b1, 16'h2004, mk_res(1'b1, 1'b0, 16'h2004, strong_nt, 1'b1, '0));
    @(negedge clk);
    check("rsp", rsp, '0);                               // Port busy on a trained entry
    drive(1'b0, 16'h2004, mk_res(1'b1, 1'b1, 16'h3006, strong_nt, 1'b1, 16'h1111));
    @(negedge clk);
    check("rsp", rsp, '0);
    drive(1'b1, 16'h3006, '0);
    @(negedge clk);
    check("rsp", rsp, '0);                               // Disabled write dropped
    drive(1'b0, 16'h2004, '0);
    @(negedge clk);
    check("rsp", rsp, '0);                               // Disabled lookup on a trained entry
    end_test("busy and disabled", err_start);

    err_start = errors;
    for (int i = 0; i < 200; i++) begin
      take_bits(3, r);
      en = (r[2:0] != 3'd0);                             // Mostly enabled
      take_bits(3, r);
      p = pc_set[r[2:0]];
      take_bits(3, r);
      res         = '0;
      res.hist_we = r[0];
      res.tgt_we  = r[1];
      res.taken   = r[2];
      take_bits(3, r);
      res.pc = pc_set[r[2:0]];
      take_bits(2, r);
      res.counter = ctr_state_e'(r[1:0]);
      take_bits(16, r);
      res.target = r;
      drive(en, p, res);
    end
    end_test("random mix", err_start);

    $display("checks run %0d, mismatches %0d", num_checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
